// File: design/axi_sram.sv
// single-beat axi sram slave with range check and timed responses
`timescale 1ns/10ps
`include "lsu_cfg.svh"

module axi_sram import lsu_pkg::*; (
    input  logic                   clock,
    input  logic                   reset,
    input  logic                   awvalid,
    output logic                   awready,
    input  logic [`LSU_XLEN-1:0]   awaddr,
    input  logic                   wvalid,
    output logic                   wready,
    input  logic [`LSU_XLEN-1:0]   wdata,
    input  logic [`LSU_XLEN/8-1:0] wstrb,
    output logic                   bvalid,
    input  logic                   bready,
    output axi_resp_e              bresp,
    input  logic                   arvalid,
    output logic                   arready,
    input  logic [`LSU_XLEN-1:0]   araddr,
    output logic                   rvalid,
    input  logic                   rready,
    output logic [`LSU_XLEN-1:0]   rdata,
    output axi_resp_e              rresp
);

    localparam int idx_w = $clog2(`LSU_SRAM_WORDS);

    logic [`LSU_XLEN-1:0] mem [`LSU_SRAM_WORDS];

    logic                 busy;
    logic                 is_read;
    logic                 wr_go;
    logic                 rd_go;
    logic                 expired;
    logic [`LSU_XLEN-1:0] wr_off;
    logic [`LSU_XLEN-1:0] rd_off;
    logic                 wr_hit;
    logic                 rd_hit;
    axi_resp_e            resp_q;
    logic [`LSU_XLEN-1:0] rdata_q;

    assign wr_go   = !busy && awvalid && wvalid;  // aw and w taken together
    assign rd_go   = !busy && arvalid && !wr_go;
    assign awready = wr_go;
    assign wready  = wr_go;
    assign arready = rd_go;

    assign wr_off = awaddr - `LSU_SRAM_BASE;
    assign rd_off = araddr - `LSU_SRAM_BASE;
    assign wr_hit = (wr_off >> 2) < `LSU_SRAM_WORDS;
    assign rd_hit = (rd_off >> 2) < `LSU_SRAM_WORDS;

    always_ff @(posedge clock) begin
        if (wr_go && wr_hit) begin
            for (int i = 0; i < `LSU_XLEN/8; i++) begin
                if (wstrb[i]) begin
                    mem[wr_off[idx_w+1:2]][i*8 +: 8] <= wdata[i*8 +: 8];
                end
            end
        end
    end

    // response payload is taken at accept and held until the handshake
    always_ff @(posedge clock) begin
        if (wr_go) begin
            resp_q <= wr_hit ? resp_okay : resp_decerr;
        end else if (rd_go) begin
            resp_q  <= rd_hit ? resp_okay : resp_decerr;
            rdata_q <= rd_hit ? mem[rd_off[idx_w+1:2]] : '0;
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            busy    <= 1'b0;
            is_read <= 1'b0;
            bvalid  <= 1'b0;
            rvalid  <= 1'b0;
        end else begin
            if (wr_go || rd_go) begin
                busy    <= 1'b1;
                is_read <= rd_go;
            end
            if (expired) begin
                bvalid <= !is_read;
                rvalid <= is_read;
            end
            if (bvalid && bready) begin
                bvalid <= 1'b0;
                busy   <= 1'b0;
            end
            if (rvalid && rready) begin
                rvalid <= 1'b0;
                busy   <= 1'b0;
            end
        end
    end

    mem_delay_timer i_mem_delay_timer (
        .clock   (clock),
        .reset   (reset),
        .start   (wr_go || rd_go),
        .expired (expired)
    );

    assign bresp = resp_q;
    assign rresp = resp_q;
    assign rdata = rdata_q;

    assert property (@(posedge clock) disable iff (reset) !(bvalid && rvalid))
        else $error("write and read responses raised together");

endmodule

// File: design/load_extend.sv
// load lane selection and sign or zero extension
`timescale 1ns/10ps
`include "lsu_cfg.svh"

module load_extend import lsu_pkg::*; (
    input  logic [2:0]           funct3,
    input  logic [`LSU_XLEN-1:0] addr,
    input  logic [`LSU_XLEN-1:0] rdata,
    output logic [`LSU_XLEN-1:0] value
);

    lane_word_u  word;
    logic [7:0]  sel_byte;
    logic [15:0] sel_half;

    assign word     = rdata;
    assign sel_byte = word.bytes[addr[1:0]];
    assign sel_half = word.halves[addr[1]];   // bit 0 ignored for halves

    always_comb begin
        case (funct3)
            3'd0: begin
                value = {{(`LSU_XLEN-8){sel_byte[7]}}, sel_byte};    // lb
            end
            3'd1: begin
                value = {{(`LSU_XLEN-16){sel_half[15]}}, sel_half};  // lh
            end
            3'd2: begin
                value = word;                                         // lw
            end
            3'd4: begin
                value = {{(`LSU_XLEN-8){1'b0}}, sel_byte};           // lbu
            end
            3'd5: begin
                value = {{(`LSU_XLEN-16){1'b0}}, sel_half};          // lhu
            end
            default: begin
                value = '0;
            end
        endcase
    end

endmodule

// File: design/lsu_cfg.svh
// data width, sram depth, response latency and sram base address macros
`ifndef LSU_CFG_SVH
`define LSU_CFG_SVH

// data and address width
`define LSU_XLEN        32

// sram depth in words
`define LSU_SRAM_WORDS  256

// cycles from address accept to b/r valid
`define LSU_MEM_LATENCY 3

// byte address of sram word 0
`define LSU_SRAM_BASE   32'h0000_0000

`endif

// File: design/lsu_fsm.sv
// memory stage FSM: operation accept, axi address/data/response phases, result hand-off
`timescale 1ns/10ps
`include "lsu_cfg.svh"

module lsu_fsm import lsu_pkg::*; (
    input  logic                   clock,
    input  logic                   reset,
    input  logic                   in_valid,
    output logic                   in_ready,
    input  lsu_op_e                in_op,
    input  logic [2:0]             in_funct3,
    input  logic [`LSU_XLEN-1:0]   in_addr,
    input  logic [`LSU_XLEN-1:0]   in_wdata,
    input  logic [`LSU_XLEN-1:0]   in_pc,
    input  logic [4:0]             in_rd,
    input  logic                   in_reg_wen,
    output logic                   out_valid,
    input  logic                   out_ready,
    output logic [`LSU_XLEN-1:0]   out_pc,
    output logic [4:0]             out_rd,
    output logic                   out_reg_wen,
    output logic [`LSU_XLEN-1:0]   out_result,
    output logic                   out_fault,
    output logic                   awvalid,
    input  logic                   awready,
    output logic [`LSU_XLEN-1:0]   awaddr,
    output logic                   wvalid,
    input  logic                   wready,
    output logic [`LSU_XLEN-1:0]   wdata,
    output logic [`LSU_XLEN/8-1:0] wstrb,
    input  logic                   bvalid,
    output logic                   bready,
    input  axi_resp_e              bresp,
    output logic                   arvalid,
    input  logic                   arready,
    output logic [`LSU_XLEN-1:0]   araddr,
    input  logic                   rvalid,
    output logic                   rready,
    input  axi_resp_e              rresp,
    input  logic [`LSU_XLEN-1:0]   store_wdata,
    input  logic [`LSU_XLEN/8-1:0] store_strb,
    input  logic [`LSU_XLEN-1:0]   load_value,
    output logic [2:0]             op_funct3,
    output logic [`LSU_XLEN-1:0]   op_addr,
    output logic [`LSU_XLEN-1:0]   op_wdata
);

    typedef enum logic [1:0] {
        st_idle,
        st_addr,
        st_resp,
        st_done
    } state_e;

    state_e               state;
    lsu_op_e              op_q;
    logic [2:0]           funct3_q;
    logic [`LSU_XLEN-1:0] addr_q;
    logic [`LSU_XLEN-1:0] wdata_q;
    logic [`LSU_XLEN-1:0] pc_q;
    logic [4:0]           rd_q;
    logic                 reg_wen_q;
    logic [`LSU_XLEN-1:0] result_q;
    logic                 fault_q;
    logic                 aw_done;
    logic                 w_done;
    logic                 in_fire;
    logic                 out_fire;
    logic                 aw_fire;
    logic                 w_fire;
    logic                 ar_fire;
    logic                 b_fire;
    logic                 r_fire;
    logic                 wr_addr_ok;

    assign in_ready  = (state == st_idle);
    assign out_valid = (state == st_done);
    assign in_fire   = in_valid && in_ready;
    assign out_fire  = out_valid && out_ready;

    assign awvalid = (state == st_addr) && (op_q == op_store) && !aw_done;
    assign wvalid  = (state == st_addr) && (op_q == op_store) && !w_done;
    assign arvalid = (state == st_addr) && (op_q == op_load);
    assign bready  = (state == st_resp) && (op_q == op_store);
    assign rready  = (state == st_resp) && (op_q == op_load);

    assign aw_fire    = awvalid && awready;
    assign w_fire     = wvalid && wready;
    assign ar_fire    = arvalid && arready;
    assign b_fire     = bvalid && bready;
    assign r_fire     = rvalid && rready;
    assign wr_addr_ok = (aw_done || aw_fire) && (w_done || w_fire);  // both phases in

    always_ff @(posedge clock) begin
        if (reset) begin
            state   <= st_idle;
            op_q    <= op_none;
            aw_done <= 1'b0;
            w_done  <= 1'b0;
        end else begin
            case (state)
                st_idle: begin
                    if (in_fire) begin
                        op_q    <= in_op;
                        aw_done <= 1'b0;
                        w_done  <= 1'b0;
                        if (in_op == op_load || in_op == op_store) begin
                            state <= st_addr;
                        end else begin
                            state <= st_done;
                        end
                    end
                end
                st_addr: begin
                    if (aw_fire) begin
                        aw_done <= 1'b1;
                    end
                    if (w_fire) begin
                        w_done <= 1'b1;
                    end
                    if ((op_q == op_load && ar_fire) || (op_q == op_store && wr_addr_ok)) begin
                        state <= st_resp;
                    end
                end
                st_resp: begin
                    if (b_fire || r_fire) begin
                        state <= st_done;
                    end
                end
                default: begin
                    if (out_fire) begin
                        state <= st_idle;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clock) begin
        if (in_fire) begin
            funct3_q  <= in_funct3;
            addr_q    <= in_addr;
            wdata_q   <= in_wdata;
            pc_q      <= in_pc;
            rd_q      <= in_rd;
            reg_wen_q <= in_reg_wen;
            result_q  <= in_addr;     // pass-through result
            fault_q   <= 1'b0;
        end else if (b_fire) begin
            result_q <= '0;           // stores write nothing back
            fault_q  <= (bresp != resp_okay);
        end else if (r_fire) begin
            result_q <= (rresp == resp_okay) ? load_value : '0;
            fault_q  <= (rresp != resp_okay);
        end
    end

    assign awaddr    = addr_q;
    assign araddr    = addr_q;
    assign wdata     = store_wdata;
    assign wstrb     = store_strb;
    assign op_funct3 = funct3_q;
    assign op_addr   = addr_q;
    assign op_wdata  = wdata_q;

    assign out_pc      = pc_q;
    assign out_rd      = rd_q;
    assign out_reg_wen = reg_wen_q;
    assign out_result  = result_q;
    assign out_fault   = fault_q;

    assert property (@(posedge clock) disable iff (reset) !(arvalid && awvalid))
        else $error("read and write address issued together");

    // result must hold under back-pressure
    assert property (@(posedge clock) disable iff (reset)
        out_valid && !out_ready |=> out_valid && $stable(out_result))
        else $error("output dropped or changed before it was accepted");

endmodule

// File: design/lsu_pkg.sv
// package with the op kind enum, the axi response enum and the lane view union
`include "lsu_cfg.svh"

package lsu_pkg;

    // what the execute stage hands over
    typedef enum logic [1:0] {
        op_none  = 2'd0,    // pass-through, result is the address
        op_load  = 2'd1,
        op_store = 2'd2
    } lsu_op_e;

    typedef enum logic [1:0] {
        resp_okay   = 2'b00,
        resp_slverr = 2'b10,
        resp_decerr = 2'b11
    } axi_resp_e;

    // one bus word seen as byte lanes or as halfword lanes
    typedef union packed {
        logic [`LSU_XLEN/8-1:0][7:0]   bytes;
        logic [`LSU_XLEN/16-1:0][15:0] halves;
    } lane_word_u;

endpackage

// File: design/mem_delay_timer.sv
// down-counter that times the sram response delay
`timescale 1ns/10ps
`include "lsu_cfg.svh"

module mem_delay_timer (
    input  logic clock,
    input  logic reset,
    input  logic start,
    output logic expired
);

    localparam int cnt_w = $clog2(`LSU_MEM_LATENCY + 1);

    logic [cnt_w-1:0] count;

    always_ff @(posedge clock) begin
        if (reset) begin
            count <= '0;
        end else if (start) begin
            count <= cnt_w'(`LSU_MEM_LATENCY);
        end else if (count != '0) begin
            count <= count - 1'b1;
        end
    end

    // high in the last cycle before the count hits zero
    assign expired = (count == cnt_w'(1));

    // the slave only restarts once its previous response is gone
    assert property (@(posedge clock) disable iff (reset) start |-> count == '0)
        else $error("delay timer restarted while still counting");

endmodule

// File: design/mem_stage.sv
// memory stage top: FSM, store and load aligners, axi sram
`timescale 1ns/10ps
`include "lsu_cfg.svh"

module mem_stage import lsu_pkg::*; (
    input  logic                 clock,
    input  logic                 reset,
    input  logic                 in_valid,
    output logic                 in_ready,
    input  lsu_op_e              in_op,
    input  logic [2:0]           in_funct3,
    input  logic [`LSU_XLEN-1:0] in_addr,
    input  logic [`LSU_XLEN-1:0] in_wdata,
    input  logic [`LSU_XLEN-1:0] in_pc,
    input  logic [4:0]           in_rd,
    input  logic                 in_reg_wen,
    output logic                 out_valid,
    input  logic                 out_ready,
    output logic [`LSU_XLEN-1:0] out_pc,
    output logic [4:0]           out_rd,
    output logic                 out_reg_wen,
    output logic [`LSU_XLEN-1:0] out_result,
    output logic                 out_fault
);

    // internal axi bus
    logic                   awvalid;
    logic                   awready;
    logic [`LSU_XLEN-1:0]   awaddr;
    logic                   wvalid;
    logic                   wready;
    logic [`LSU_XLEN-1:0]   wdata;
    logic [`LSU_XLEN/8-1:0] wstrb;
    logic                   bvalid;
    logic                   bready;
    axi_resp_e              bresp;
    logic                   arvalid;
    logic                   arready;
    logic [`LSU_XLEN-1:0]   araddr;
    logic                   rvalid;
    logic                   rready;
    logic [`LSU_XLEN-1:0]   rdata;
    axi_resp_e              rresp;

    // aligner hookup
    logic [`LSU_XLEN-1:0]   store_wdata;
    logic [`LSU_XLEN/8-1:0] store_strb;
    logic [`LSU_XLEN-1:0]   load_value;
    logic [2:0]             op_funct3;
    logic [`LSU_XLEN-1:0]   op_addr;
    logic [`LSU_XLEN-1:0]   op_wdata;

    lsu_fsm i_lsu_fsm (.*);

    store_align i_store_align (
        .funct3 (op_funct3),
        .addr   (op_addr),
        .data   (op_wdata),
        .wdata  (store_wdata),
        .wstrb  (store_strb)
    );

    load_extend i_load_extend (
        .funct3 (op_funct3),
        .addr   (op_addr),
        .rdata  (rdata),
        .value  (load_value)
    );

    axi_sram i_axi_sram (.*);

endmodule

// File: design/store_align.sv
// store data lane shift and byte strobe generation
`timescale 1ns/10ps
`include "lsu_cfg.svh"

module store_align import lsu_pkg::*; (
    input  logic [2:0]             funct3,
    input  logic [`LSU_XLEN-1:0]   addr,
    input  logic [`LSU_XLEN-1:0]   data,
    output logic [`LSU_XLEN-1:0]   wdata,
    output logic [`LSU_XLEN/8-1:0] wstrb
);

    lane_word_u             src;
    lane_word_u             dst;
    logic [1:0]             offset;
    logic [`LSU_XLEN/8-1:0] base_strb;

    assign src    = data;
    assign offset = addr[1:0];     // byte offset in the word
    assign wdata  = dst;

    always_comb begin
        dst = '0;
        for (int i = 0; i < `LSU_XLEN/8; i++) begin
            if (i >= offset) begin
                dst.bytes[i] = src.bytes[i - offset];  // high bytes drop off
            end
        end
    end

    always_comb begin
        case (funct3)
            3'd0:    base_strb = 4'b0001;  // sb
            3'd1:    base_strb = 4'b0011;  // sh
            3'd2:    base_strb = 4'b1111;  // sw
            default: base_strb = 4'b0000;
        endcase
    end

    assign wstrb = base_strb << offset;

endmodule

// File: mem_stage.f
+incdir+design
design/lsu_pkg.sv
design/mem_delay_timer.sv
design/store_align.sv
design/load_extend.sv
design/axi_sram.sv
design/lsu_fsm.sv
design/mem_stage.sv
sim/tb_clock_gen.sv
sim/mem_stage_tb.sv

// File: run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module mem_stage_tb \
    -f mem_stage.f -o mem_stage_sim

out=$(./obj_dir/mem_stage_sim)
echo "$out"
echo "$out" | grep -q "^Simulation passed$"

// File: sim/mem_stage_golden.txt
# op funct3 addr wdata pc rd reg_wen expected_result expected_fault
# op is 0 pass-through, 1 load, 2 store; every field is hex
0 0 12345678 00000000 00000100 01 1 12345678 0
0 7 deadbeef 00000000 00000104 1f 0 deadbeef 0
2 2 00000040 11223344 00000108 00 0 00000000 0
2 0 00000041 000000aa 0000010c 00 0 00000000 0
2 1 00000042 0000beef 00000110 00 0 00000000 0
1 2 00000040 00000000 00000114 05 1 beefaa44 0
2 2 00000044 8091a2b3 00000118 00 0 00000000 0
2 2 00000048 7f6e5d4c 0000011c 00 0 00000000 0
1 0 00000044 00000000 00000120 06 1 ffffffb3 0
1 0 00000045 00000000 00000124 07 1 ffffffa2 0
1 0 00000046 00000000 00000128 08 1 ffffff91 0
1 0 00000047 00000000 0000012c 09 1 ffffff80 0
1 0 00000048 00000000 00000130 0a 1 0000004c 0
1 4 00000044 00000000 00000134 0b 1 000000b3 0
1 4 00000045 00000000 00000138 0c 1 000000a2 0
1 4 00000046 00000000 0000013c 0d 1 00000091 0
1 4 00000047 00000000 00000140 0e 1 00000080 0
1 1 00000044 00000000 00000144 0f 1 ffffa2b3 0
1 1 00000046 00000000 00000148 10 1 ffff8091 0
1 1 0000004a 00000000 0000014c 11 1 00007f6e 0
1 5 00000044 00000000 00000150 12 1 0000a2b3 0
1 5 00000046 00000000 00000154 13 1 00008091 0
2 2 00000440 cafef00d 00000158 00 0 00000000 1
1 2 00001000 00000000 0000015c 14 1 00000000 1
1 0 7ffffff1 00000000 00000160 15 1 00000000 1
1 2 00000040 00000000 00000164 16 1 beefaa44 0
0 0 00000abc 00000000 00000168 17 1 00000abc 0

// File: sim/mem_stage_tb.sv
// memory stage testbench driven by the golden operation file
`timescale 1ns/10ps
`include "lsu_cfg.svh"

module mem_stage_tb import lsu_pkg::*; ;

    localparam int wait_limit   = 200;       // cycles per handshake wait
    localparam int reset_limit  = 20;
    localparam int run_limit_ns = 1000000;

    logic                 clock;
    logic                 reset;
    logic                 in_valid;
    logic                 in_ready;
    lsu_op_e              in_op;
    logic [2:0]           in_funct3;
    logic [`LSU_XLEN-1:0] in_addr;
    logic [`LSU_XLEN-1:0] in_wdata;
    logic [`LSU_XLEN-1:0] in_pc;
    logic [4:0]           in_rd;
    logic                 in_reg_wen;
    logic                 out_valid;
    logic                 out_ready;
    logic [`LSU_XLEN-1:0] out_pc;
    logic [4:0]           out_rd;
    logic                 out_reg_wen;
    logic [`LSU_XLEN-1:0] out_result;
    logic                 out_fault;

    int value_errors = 0;
    int timeouts     = 0;
    int order_errors = 0;
    int setup_errors = 0;
    int presented    = 0;
    int op_count     = 0;

    logic valid_seen = 1'b0;

    tb_clock_gen i_clock_gen (
        .clock (clock),
        .reset (reset)
    );

    mem_stage i_mem_stage (
        .clock       (clock),
        .reset       (reset),
        .in_valid    (in_valid),
        .in_ready    (in_ready),
        .in_op       (in_op),
        .in_funct3   (in_funct3),
        .in_addr     (in_addr),
        .in_wdata    (in_wdata),
        .in_pc       (in_pc),
        .in_rd       (in_rd),
        .in_reg_wen  (in_reg_wen),
        .out_valid   (out_valid),
        .out_ready   (out_ready),
        .out_pc      (out_pc),
        .out_rd      (out_rd),
        .out_reg_wen (out_reg_wen),
        .out_result  (out_result),
        .out_fault   (out_fault)
    );

    // counts every new rise of out_valid over the whole run
    always @(negedge clock) begin
        if (!reset && out_valid && !valid_seen) begin
            presented++;
        end
        valid_seen = !reset && out_valid;
    end

    task automatic send_op(input lsu_op_e op, input logic [2:0] funct3,
                           input logic [31:0] addr, input logic [31:0] wdata,
                           input logic [31:0] pc, input logic [4:0] rd, input logic wen);
        int waited;
        waited = 0;
        @(posedge clock);
        in_valid   <= 1'b1;
        in_op      <= op;
        in_funct3  <= funct3;
        in_addr    <= addr;
        in_wdata   <= wdata;
        in_pc      <= pc;
        in_rd      <= rd;
        in_reg_wen <= wen;
        @(negedge clock);
        while (!in_ready && waited < wait_limit) begin
            @(negedge clock);
            waited++;
        end
        if (!in_ready) begin
            $display("timed out waiting for in_ready at pc %h", pc);
            timeouts++;
        end
        @(posedge clock);   // transfer edge
        in_valid <= 1'b0;
    endtask

    task automatic take_result(input logic [31:0] exp_pc, input logic [4:0] exp_rd,
                               input logic exp_wen, input logic [31:0] exp_result,
                               input logic exp_fault);
        int          waited;
        logic        seen;
        logic        done;
        logic [31:0] held_result;
        logic [31:0] held_pc;
        logic [4:0]  held_rd;
        logic        held_wen;
        logic        held_fault;
        waited      = 0;
        seen        = 1'b0;
        done        = 1'b0;
        held_result = '0;
        held_pc     = '0;
        held_rd     = '0;
        held_wen    = 1'b0;
        held_fault  = 1'b0;
        while (!done && waited < wait_limit) begin
            @(posedge clock);
            out_ready <= ($urandom_range(0, 3) != 0);   // stall about a quarter of cycles
            @(negedge clock);
            assert (!in_ready)
                else begin
                    $display("FAIL %0t: in_ready high while pc %h is in flight", $time, exp_pc);
                    value_errors++;
                end
            if (out_valid) begin
                if (seen) begin
                    assert (out_result === held_result && out_pc === held_pc &&
                            out_rd === held_rd && out_reg_wen === held_wen &&
                            out_fault === held_fault)
                        else begin
                            $display("FAIL %0t: output changed under stall at pc %h",
                                     $time, exp_pc);
                            value_errors++;
                        end
                end
                held_result = out_result;
                held_pc     = out_pc;
                held_rd     = out_rd;
                held_wen    = out_reg_wen;
                held_fault  = out_fault;
                seen        = 1'b1;
                done        = out_ready;
            end
            waited++;
        end
        if (!done) begin
            $display("timed out waiting for out_valid at pc %h", exp_pc);
            timeouts++;
        end else begin
            assert (out_result === exp_result && out_fault === exp_fault)
                else begin
                    $display("FAIL %0t: pc %h result %h fault %b, expected %h fault %b",
                             $time, exp_pc, out_result, out_fault, exp_result, exp_fault);
                    value_errors++;
                end
            assert (out_pc === exp_pc && out_rd === exp_rd && out_reg_wen === exp_wen)
                else begin
                    $display("FAIL %0t: pc %h rd %h wen %b, expected pc %h rd %h wen %b",
                             $time, out_pc, out_rd, out_reg_wen, exp_pc, exp_rd, exp_wen);
                    value_errors++;
                end
        end
        @(posedge clock);
        out_ready <= 1'b0;
        @(negedge clock);
        if (done && out_valid) begin
            $display("result for pc %h was presented again after it was taken", exp_pc);
            order_errors++;
        end
    endtask

    initial begin
        int          fd;
        int          code;
        int          waited;
        string       line;
        logic [31:0] f_op;
        logic [31:0] f_f3;
        logic [31:0] f_addr;
        logic [31:0] f_wdata;
        logic [31:0] f_pc;
        logic [31:0] f_rd;
        logic [31:0] f_wen;
        logic [31:0] f_exp;
        logic [31:0] f_fault;
        in_valid   = 1'b0;
        in_op      = op_none;
        in_funct3  = '0;
        in_addr    = '0;
        in_wdata   = '0;
        in_pc      = '0;
        in_rd      = '0;
        in_reg_wen = 1'b0;
        out_ready  = 1'b0;
        void'($urandom(32'h13e6));
        fd = $fopen("sim/mem_stage_golden.txt", "r");
        if (fd == 0) begin
            $display("could not open the golden file sim/mem_stage_golden.txt");
            setup_errors++;
        end

        waited = 0;
        @(negedge clock);
        while (reset && waited < reset_limit) begin
            @(negedge clock);
            waited++;
        end
        if (reset) begin
            $display("reset was never released");
            timeouts++;
        end
        assert (in_ready === 1'b1 && out_valid === 1'b0)
            else begin
                $display("FAIL %0t: after reset in_ready %b out_valid %b", $time,
                         in_ready, out_valid);
                value_errors++;
            end

        while (fd != 0 && !$feof(fd)) begin
            code = $fgets(line, fd);
            if (code > 0 && $sscanf(line, "%h %h %h %h %h %h %h %h %h", f_op, f_f3, f_addr,
                                    f_wdata, f_pc, f_rd, f_wen, f_exp, f_fault) == 9) begin
                repeat ($urandom_range(0, 2)) @(posedge clock);   // idle gap
                send_op(lsu_op_e'(f_op[1:0]), f_f3[2:0], f_addr, f_wdata, f_pc,
                        f_rd[4:0], f_wen[0]);
                take_result(f_pc, f_rd[4:0], f_wen[0], f_exp, f_fault[0]);
                op_count++;
            end
        end
        if (fd != 0) begin
            $fclose(fd);
        end

        if (op_count == 0) begin
            $display("no operations were read from the golden file");
            setup_errors++;
        end
        if (presented != op_count) begin
            $display("%0d results were presented for %0d operations", presented, op_count);
            order_errors++;
        end

        $display("errors: %0d value, %0d timeout, %0d order, %0d setup",
                 value_errors, timeouts, order_errors, setup_errors);
        if (value_errors == 0 && timeouts == 0 && order_errors == 0 && setup_errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    initial begin
        #(run_limit_ns);
        $display("run limit reached before the golden file was done");
        $display("Simulation failed");
        $finish;
    end

endmodule

// File: sim/tb_clock_gen.sv
// testbench clock and power-on reset generator
`timescale 1ns/10ps

module tb_clock_gen #(
    parameter int half_period_ns = 20,
    parameter int reset_cycles   = 8
) (
    output logic clock,
    output logic reset
);

    initial begin
        clock = 1'b0;
        forever #(half_period_ns) clock = ~clock;   // 40 ns period
    end

    initial begin
        reset = 1'b1;
        repeat (reset_cycles) @(posedge clock);
        reset <= 1'b0;
    end

endmodule
